/* source/cpu_types_pkg.sv */
// shared widths, opcode and funct encodings, instruction views and stage bundles for the backend
package cpu_types_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regbits_t;

    // link register used by jal
    localparam regbits_t REG_LINK = 5'd31;

    // primary opcodes in use by the backend
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        JAL   = 6'h03,
        LUI   = 6'h0f,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f
    } opcode_t;

    // r-type function field, only carried along past execute
    typedef enum logic [5:0] {
        SLL   = 6'h00,
        SRL   = 6'h02,
        JR    = 6'h08,
        ADD   = 6'h20,
        ADDU  = 6'h21,
        SUB   = 6'h22,
        SUBU  = 6'h23,
        AND   = 6'h24,
        OR    = 6'h25,
        XOR   = 6'h26,
        NOR   = 6'h27,
        SLT   = 6'h2a,
        SLTU  = 6'h2b
    } funct_t;

    // register-register layout
    typedef struct packed {
        opcode_t  opcode;
        regbits_t rs;
        regbits_t rt;
        regbits_t rd;
        logic [4:0] shamt;
        funct_t   funct;
    } rtype_t;

    // immediate layout
    typedef struct packed {
        opcode_t     opcode;
        regbits_t    rs;
        regbits_t    rt;
        logic [15:0] imm16;
    } itype_t;

    // one instruction word, two decodes
    typedef union packed {
        rtype_t rtype;
        itype_t itype;
    } instr_u;

    // bundle handed over by execute
    typedef struct packed {
        logic   jal_s;
        logic   lui;
        logic   mem_read;
        logic   mem_write;
        logic   MemtoReg;
        logic   RegWr;
        logic   halt;
        word_t  pcplusfour;
        instr_u instr;
        word_t  alu_portOut;
        word_t  rdat2;
    } ex_mem_t;

    // bundle held in the mem/wb latch
    typedef struct packed {
        logic   jal_s;
        logic   lui;
        logic   MemtoReg;
        logic   RegWr;
        logic   halt;
        word_t  pcplusfour;
        instr_u instr;
        word_t  alu_portOut;
        word_t  wdat;
    } mem_wb_t;

    // register file write request
    typedef struct packed {
        logic     wen;
        regbits_t wsel;
        word_t    wdat;
    } wb_req_t;

endpackage

/* source/data_mem.sv */
// word-addressed data RAM with a programmable wait-state count and a one-cycle done strobe
`timescale 1ns/10ps

module data_mem #(
    parameter int DMEM_WORDS = 256,
    parameter int DMEM_WAIT  = 2
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 ren,
    input  logic                 wen,
    input  cpu_types_pkg::word_t addr,
    input  cpu_types_pkg::word_t wdata,
    output cpu_types_pkg::word_t rdata,
    output logic                 done
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;
    localparam int CNT_W = (DMEM_WAIT > 1) ? $clog2(DMEM_WAIT) : 1;

    cpu_types_pkg::word_t mem [DMEM_WORDS];

    logic             req;
    logic             start;
    logic             fire;
    logic             busy;
    // access finished but request still up
    logic             held;
    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] idx;

    assign req   = ren || wen;
    assign start = req && !busy && !held;
    // single wait state finishes on the first edge that sees the request
    assign fire  = busy ? (cnt == '0) : (start && DMEM_WAIT == 1);
    // word index, byte offset dropped, wrapped on the depth
    assign idx   = IDX_W'(addr[31:2] % DMEM_WORDS);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            held  <= 1'b0;
            cnt   <= '0;
            done  <= 1'b0;
            rdata <= '0;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            done <= fire;
            // hold off a restart until the requester lets go
            held <= (fire || held) && req;
            if (fire) begin
                busy <= 1'b0;
                if (wen) begin
                    mem[idx] <= wdata;
                end
                if (ren) begin
                    rdata <= mem[idx];
                end
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end else if (start) begin
                // first edge already counts as one wait cycle
                busy <= 1'b1;
                cnt  <= CNT_W'(DMEM_WAIT - 2);
            end
        end
    end

endmodule

/* source/mem_stage.sv */
// memory stage: issues data memory requests for the ex/mem bundle, raises stall, builds mem/wb input
`timescale 1ns/10ps

module mem_stage (
    input  logic                   CLK,
    input  logic                   nRST,
    input  cpu_types_pkg::ex_mem_t ex_mem,
    input  logic                   ihit,
    input  logic                   dmem_done,
    input  cpu_types_pkg::word_t   dmem_rdata,
    output logic                   dmem_ren,
    output logic                   dmem_wen,
    output cpu_types_pkg::word_t   dmem_addr,
    output cpu_types_pkg::word_t   dmem_wdata,
    output cpu_types_pkg::mem_wb_t mw_in,
    output logic                   stall
);

    // bundle wants the data memory this cycle
    logic mem_op;
    // bundle leaves the stage on this edge
    logic accept;
    // access already finished, waiting for the bundle to be taken
    logic completed;
    // load data kept after the done pulse
    cpu_types_pkg::word_t load_q;

    // only a presented bundle (ihit high) is allowed to touch memory
    assign mem_op = ihit && (ex_mem.mem_read || ex_mem.mem_write);

    // hold upstream until done shows up, done cycle itself is stall free
    assign stall  = mem_op && !completed && !dmem_done;
    assign accept = ihit && !stall;

    // request drops in the done cycle so data_mem sees it fall before a new one
    assign dmem_ren = ihit && ex_mem.mem_read && !completed && !dmem_done;
    assign dmem_wen = ihit && ex_mem.mem_write && !completed && !dmem_done;

    // address from the alu, store data from the second read port
    assign dmem_addr  = ex_mem.alu_portOut;
    assign dmem_wdata = ex_mem.rdat2;

    // completed flag
    // set by done, cleared once the bundle is accepted
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            completed <= 1'b0;
        end else if (accept) begin
            completed <= 1'b0;
        end else if (dmem_done) begin
            completed <= 1'b1;
        end
    end

    // capture the read word on done in case the bundle waits on ihit
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            load_q <= '0;
        end else if (dmem_done) begin
            load_q <= dmem_rdata;
        end
    end

    // forward control and word fields into the latch input
    always_comb begin
        mw_in.jal_s       = ex_mem.jal_s;
        mw_in.lui         = ex_mem.lui;
        mw_in.MemtoReg    = ex_mem.MemtoReg;
        mw_in.RegWr       = ex_mem.RegWr;
        mw_in.halt        = ex_mem.halt;
        mw_in.pcplusfour  = ex_mem.pcplusfour;
        mw_in.instr       = ex_mem.instr;
        mw_in.alu_portOut = ex_mem.alu_portOut;
        // fresh data during done, captured copy afterwards
        mw_in.wdat        = dmem_done ? dmem_rdata : load_q;
    end

endmodule

/* source/mem_wrb.sv */
// mem/wb pipeline register between the memory stage and writeback
`timescale 1ns/10ps

module mem_wrb (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   ihit,
    input  logic                   stall,
    input  cpu_types_pkg::mem_wb_t mw_in,
    output cpu_types_pkg::mem_wb_t mw_out
);

    // latch update rules, in priority order
    //   reset  clears everything, so RegWr and halt start inactive
    //   stall  freezes the current bundle
    //   ihit   takes the bundle from the memory stage
    //   else   keeps the value, upstream has nothing new
    //
    // the whole bundle moves as one struct, fields stay aligned
    // with the memory stage output without per-field copies

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mw_out <= '0;
        end else if (stall) begin
            // memory access still pending, keep what writeback sees
            mw_out <= mw_out;
        end else if (ihit) begin
            mw_out <= mw_in;
        end
    end

    // note a held bundle with RegWr set keeps writing the same value
    // into the same register each cycle, which is harmless

    // halt is sticky in practice: once latched it stays until
    // a new bundle replaces it, and upstream stops issuing after halt

endmodule

/* source/writeback.sv */
// writeback: picks destination register and write value from the latched mem/wb bundle
`timescale 1ns/10ps

module writeback (
    input  cpu_types_pkg::mem_wb_t mw_out,
    output cpu_types_pkg::wb_req_t wb
);

    // instruction word seen through both layouts
    cpu_types_pkg::instr_u ins;
    cpu_types_pkg::regbits_t dest;
    cpu_types_pkg::word_t    value;

    assign ins = mw_out.instr;

    // destination select
    // jal links into r31, r-type writes rd, everything else writes rt
    always_comb begin
        if (mw_out.jal_s) begin
            dest = cpu_types_pkg::REG_LINK;
        end else if (ins.rtype.opcode == cpu_types_pkg::RTYPE) begin
            dest = ins.rtype.rd;
        end else begin
            dest = ins.itype.rt;
        end
    end

    // write value select
    always_comb begin
        if (mw_out.jal_s) begin
            value = mw_out.pcplusfour;
        end else if (mw_out.lui) begin
            // upper immediate, low half zero
            value = {ins.itype.imm16, 16'h0000};
        end else if (mw_out.MemtoReg) begin
            value = mw_out.wdat;
        end else begin
            value = mw_out.alu_portOut;
        end
    end

    assign wb.wen  = mw_out.RegWr;
    assign wb.wsel = dest;
    assign wb.wdat = value;

endmodule

/* source/reg_file.sv */
// 32-entry register file, one write port from writeback and one read port for observation
`timescale 1ns/10ps

module reg_file (
    input  logic                    CLK,
    input  logic                    nRST,
    input  cpu_types_pkg::wb_req_t  wb,
    input  cpu_types_pkg::regbits_t rsel,
    output cpu_types_pkg::word_t    rdat
);

    cpu_types_pkg::word_t regs [32];

    // register zero never takes a write
    logic wr_ok;

    assign wr_ok = wb.wen && (wb.wsel != '0);

    // write port
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb.wsel] <= wb.wdat;
        end
    end

    // read port, combinational
    // r0 forced to zero on the read side as well
    always_comb begin
        if (rsel == '0) begin
            rdat = '0;
        end else begin
            rdat = regs[rsel];
        end
    end

    // no write-through bypass
    // a value written at an edge shows on rdat right after that edge

endmodule

/* source/cpu_backend.sv */
// backend top: memory stage, data memory, mem/wb latch, writeback and register file
`timescale 1ns/10ps

module cpu_backend #(
    parameter int DMEM_WORDS = 256,
    parameter int DMEM_WAIT  = 2
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  cpu_types_pkg::ex_mem_t  ex_mem,
    input  logic                    ihit,
    input  cpu_types_pkg::regbits_t rsel,
    output logic                    stall,
    output logic                    halt,
    output cpu_types_pkg::word_t    rdat
);

    // data memory request and response
    logic                   dmem_ren;
    logic                   dmem_wen;
    logic                   dmem_done;
    cpu_types_pkg::word_t   dmem_addr;
    cpu_types_pkg::word_t   dmem_wdata;
    cpu_types_pkg::word_t   dmem_rdata;

    // latch input and output, writeback request
    cpu_types_pkg::mem_wb_t mw_in;
    cpu_types_pkg::mem_wb_t mw_out;
    cpu_types_pkg::wb_req_t wb;

    mem_stage i_mem_stage (
        .CLK, .nRST, .ex_mem, .ihit,
        .dmem_done, .dmem_rdata,
        .dmem_ren, .dmem_wen, .dmem_addr, .dmem_wdata,
        .mw_in, .stall
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS),
        .DMEM_WAIT  (DMEM_WAIT)
    ) i_data_mem (
        .CLK, .nRST,
        .ren   (dmem_ren),
        .wen   (dmem_wen),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata),
        .done  (dmem_done)
    );

    mem_wrb i_mem_wrb (.CLK, .nRST, .ihit, .stall, .mw_in, .mw_out);

    writeback i_writeback (.mw_out, .wb);

    reg_file i_reg_file (.CLK, .nRST, .wb, .rsel, .rdat);

    // halt comes straight from the latched bundle
    assign halt = mw_out.halt;

endmodule

/* verif/cpu_backend_asserts.sv */
// concurrent checks on stall, mem/wb latch hold and r0 writes, bound into the backend top
`timescale 1ns/10ps

module cpu_backend_asserts #(
    parameter int DMEM_WAIT = 2
) (
    input logic                   CLK,
    input logic                   nRST,
    input logic                   stall,
    input cpu_types_pkg::mem_wb_t mw_out,
    input cpu_types_pkg::wb_req_t wb,
    input cpu_types_pkg::word_t   r0_word
);

    // latch frozen while the memory stage holds upstream
    latch_hold_on_stall: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> $stable(mw_out))
        else $error("mw_out changed while stall was high");

    // a load or store holds upstream for exactly the wait states, then lets go
    stall_lasts_wait_states: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(stall) |-> stall [*DMEM_WAIT] ##1 !stall)
        else $error("stall length did not match the data memory wait states");

    // a write aimed at r0 leaves the stored r0 word at zero
    r0_stays_zero: assert property (@(posedge CLK) disable iff (!nRST)
        (wb.wen && (wb.wsel == '0)) |=> (r0_word == '0))
        else $error("register zero storage changed after a write aimed at it");

endmodule

bind cpu_backend cpu_backend_asserts #(
    .DMEM_WAIT (DMEM_WAIT)
) i_cpu_backend_asserts (
    .CLK     (CLK),
    .nRST    (nRST),
    .stall   (stall),
    .mw_out  (mw_out),
    .wb      (wb),
    .r0_word (i_reg_file.regs[0])
);

/* verif/cpu_backend_tb.sv */
// testbench for the backend: plays execute from a vectors file, checks register readback and halt
`timescale 1ns/10ps

module cpu_backend_tb;

    localparam int DMEM_WORDS = 256;
    localparam int DMEM_WAIT  = 2;
    localparam int unsigned SEED = 32'h33f8_db72;

    // one vector line: bundle, register to read back, value expected there
    typedef struct packed {
        cpu_types_pkg::ex_mem_t  bundle;
        cpu_types_pkg::regbits_t rsel;
        cpu_types_pkg::word_t    expect_val;
    } vector_t;

    logic                    CLK;
    logic                    nRST;
    cpu_types_pkg::ex_mem_t  ex_mem;
    logic                    ihit;
    cpu_types_pkg::regbits_t rsel;
    logic                    stall;
    logic                    halt;
    cpu_types_pkg::word_t    rdat;

    vector_t vectors[$];
    bit      vectors_loaded;

    cpu_backend #(
        .DMEM_WORDS (DMEM_WORDS),
        .DMEM_WAIT  (DMEM_WAIT)
    ) i_cpu_backend (
        .CLK, .nRST, .ex_mem, .ihit, .rsel,
        .stall, .halt, .rdat
    );

    // 20 ns clock
    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error: time %0t, %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    // parse the vectors file, '#' lines are comments
    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [6:0]  ctrl;
        logic [31:0] pc;
        logic [31:0] instr_w;
        logic [31:0] alu;
        logic [31:0] rdat2;
        logic [4:0]  sel;
        logic [31:0] exp_val;
        vector_t     v;
        fd = $fopen("verif/cpu_backend_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the vectors file verif/cpu_backend_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() >= 2 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%b %h %h %h %h %h %h",
                                     ctrl, pc, instr_w, alu, rdat2, sel, exp_val);
                    if (fields != 7) begin
                        abort_run($sformatf("malformed vector line: %s", line));
                    end else begin
                        // control columns in bundle order
                        v = '0;
                        v.bundle.jal_s       = ctrl[6];
                        v.bundle.lui         = ctrl[5];
                        v.bundle.mem_read    = ctrl[4];
                        v.bundle.mem_write   = ctrl[3];
                        v.bundle.MemtoReg    = ctrl[2];
                        v.bundle.RegWr       = ctrl[1];
                        v.bundle.halt        = ctrl[0];
                        v.bundle.pcplusfour  = pc;
                        v.bundle.instr       = instr_w;
                        v.bundle.alu_portOut = alu;
                        v.bundle.rdat2       = rdat2;
                        v.rsel               = sel;
                        v.expect_val         = exp_val;
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // watchdog, budget scales with the vector count and the wait states
    initial begin
        int watchdog_cycles;
        wait (vectors_loaded);
        watchdog_cycles = vectors.size() * (DMEM_WAIT + 6) + 20;
        repeat (watchdog_cycles) @(posedge CLK);
        abort_run($sformatf("timeout: run did not finish within %0d clock cycles",
                            watchdog_cycles));
    end

    initial begin
        vector_t     v;
        logic        mem_access;
        logic        stall_seen;
        int unsigned idle;
        void'($urandom(SEED));
        nRST       = 1'b0;
        ex_mem     = '0;
        ihit       = 1'b0;
        rsel       = '0;
        load_vectors();
        if (vectors.size() == 0) begin
            abort_run("the vectors file holds no vectors");
        end
        vectors_loaded = 1'b1;
        // reset for 3 cycles
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        foreach (vectors[i]) begin
            v          = vectors[i];
            mem_access = v.bundle.mem_read || v.bundle.mem_write;
            @(posedge CLK);
            ex_mem <= v.bundle;
            ihit   <= 1'b1;
            // hold the bundle while stall is up, look at it mid-cycle
            stall_seen = 1'b0;
            @(negedge CLK);
            while (stall) begin
                stall_seen = 1'b1;
                @(negedge CLK);
            end
            // acceptance edge, upstream goes idle after it
            @(posedge CLK);
            ihit   <= 1'b0;
            ex_mem <= '0;
            check_value("stall_seen", 32'(mem_access), 32'(stall_seen));
            // latch took it on the acceptance edge, register write on the next one
            @(posedge CLK);
            @(posedge CLK);
            rsel <= v.rsel;
            @(negedge CLK);
            check_value($sformatf("rdat[r%0d]", v.rsel), v.expect_val, rdat);
            check_value("halt", 32'(v.bundle.halt), 32'(halt));
            // halt must survive idle cycles
            if (v.bundle.halt) begin
                repeat (4) begin
                    @(negedge CLK);
                    check_value("halt", 32'd1, 32'(halt));
                end
            end
            idle = $urandom % 3;
            repeat (idle) @(posedge CLK);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* flist.f */
source/cpu_types_pkg.sv
source/data_mem.sv
source/mem_stage.sv
source/mem_wrb.sv
source/writeback.sv
source/reg_file.sv
source/cpu_backend.sv
verif/cpu_backend_asserts.sv
verif/cpu_backend_tb.sv

/* verif/cpu_backend_vectors.txt */
# ctrl bits jal_s lui mem_read mem_write MemtoReg RegWr halt, then hex pcplusfour instr
# alu_portOut rdat2, register to read back, expected read value
0000010 00400004 00221820 12345678 00000000 03 12345678
0000010 00400008 00854025 deadbeef 00000000 08 deadbeef
# store then load the same word
0001000 0040000c ac220010 00000040 cafef00d 02 00000000
0010110 00400010 8c290040 00000040 00000000 09 cafef00d
0001000 00400014 ac2a0080 00000080 0badf00d 0a 00000000
0010110 00400018 8c2a0080 00000080 00000000 0a 0badf00d
# word never written reads zero
0010110 0040001c 8c2b0100 00000100 00000000 0b 00000000
# address wraps on the memory depth
0001000 00400020 ac2c0404 00000404 11112222 0c 00000000
0010110 00400024 8c2c0004 00000004 00000000 0c 11112222
# upper immediate, alu value ignored
0100010 00400028 3c0dbeef 5555aaaa 00000000 0d beef0000
0100010 0040002c 3c0e8001 00000000 00000000 0e 80010000
# jal links into r31
1000010 00400034 0c000100 00000000 00000000 1f 00400034
# writes aimed at r0
0000010 00400038 00220020 ffffffff 00000000 00 00000000
0010110 0040003c 8c200040 00000040 00000000 00 00000000
0100010 00400040 3c00ffff 00000000 00000000 00 00000000
# overwrite earlier registers
0000010 00400044 00221820 0000abcd 00000000 03 0000abcd
1000010 00400104 0c000200 00000000 00000000 1f 00400104
0010110 00400108 8c290080 00000080 00000000 09 0badf00d
# halt last
0000001 0040010c fc000000 00000000 00000000 03 0000abcd
